//--- mem_subsys.f
source/rv_isa_pkg.sv
source/pipe_pkg.sv
source/pipe_stage_reg.sv
source/mem_access_stage.sv
source/data_ram.sv
source/mem_subsys_top.sv
testbench/tb_clock_gen.sv
testbench/mem_subsys_checker.sv
testbench/mem_subsys_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the memory subsystem testbench with Verilator and run it.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module mem_subsys_tb \
  -f mem_subsys.f

# The log decides the verdict, so a non-zero exit here is not fatal.
./obj_dir/Vmem_subsys_tb > sim.log 2>&1 || true
cat sim.log

if grep -qx "SIMULATION PASSED" sim.log; then
  echo "Run passed"
else
  echo "Run failed"
  exit 1
fi

//--- source/data_ram.sv
`timescale 1ns/1ps

module data_ram #(
  parameter int RAM_WORDS   = 256,
  parameter int RAM_LATENCY = 2
) (
  input  logic                          clk,
  input  logic                          rst_i,
  input  logic                          mem_req_i,
  output logic                          mem_ack_o,
  input  logic                          mem_we_i,
  input  logic [$clog2(RAM_WORDS)-1:0]  mem_addr_i,
  input  logic [3:0]                    mem_wmask_i,
  input  logic [rv_isa_pkg::XLEN-1:0]   mem_wdata_i,
  output logic [rv_isa_pkg::XLEN-1:0]   mem_rdata_o
);

  localparam int CNT_W = $clog2(RAM_LATENCY + 1);

  logic [rv_isa_pkg::XLEN-1:0] mem_q [RAM_WORDS];
  logic [rv_isa_pkg::XLEN-1:0] rdata_q;
  logic [CNT_W-1:0]            cnt_q;  // Cycles the request has waited.
  logic                        ack_q;
  logic                        fire;

  // Last wait cycle of an open request.
  assign fire = mem_req_i && !ack_q && (cnt_q == CNT_W'(RAM_LATENCY - 1));

  always_ff @(posedge clk) begin
    if (rst_i) begin
      cnt_q <= '0;
      ack_q <= 1'b0;
    end else begin
      if (fire) begin
        ack_q <= 1'b1;
        cnt_q <= '0;
      end else if (mem_req_i && !ack_q) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (!mem_req_i && ack_q) begin
        ack_q <= 1'b0;  // Req dropped, close the handshake.
      end
    end
  end

  // Access happens on the edge where ack rises.
  always_ff @(posedge clk) begin
    if (fire) begin
      rdata_q <= mem_q[mem_addr_i];
      if (mem_we_i) begin
        for (int i = 0; i < 4; i++) begin
          if (mem_wmask_i[i]) mem_q[mem_addr_i][8*i +: 8] <= mem_wdata_i[8*i +: 8];
        end
      end
    end
  end

  assign mem_ack_o   = ack_q;
  assign mem_rdata_o = rdata_q;

endmodule

//--- source/mem_access_stage.sv
`timescale 1ns/1ps

module mem_access_stage #(
  parameter int RAM_WORDS = 256
) (
  input  logic                               clk,
  input  logic                               rst_i,
  input  logic                               in_req_i,
  output logic                               in_ack_o,
  input  pipe_pkg::ex_mem_t                  in_data_i,
  input  logic [pipe_pkg::TRAP_LEN-1:0]      in_trap_i,
  output logic                               mem_req_o,
  input  logic                               mem_ack_i,
  output logic                               mem_we_o,
  output logic [$clog2(RAM_WORDS)-1:0]       mem_addr_o,
  output logic [3:0]                         mem_wmask_o,
  output logic [rv_isa_pkg::XLEN-1:0]        mem_wdata_o,
  input  logic [rv_isa_pkg::XLEN-1:0]        mem_rdata_i,
  output logic                               res_req_o,
  input  logic                               res_ack_i,
  output pipe_pkg::mem_wb_t                  res_data_o
);

  localparam int AW = $clog2(RAM_WORDS);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_DECODE,  // Alignment known, pick RAM or bypass.
    ST_MEM,     // RAM handshake open.
    ST_FORMAT,  // Build the result.
    ST_RESP,
    ST_DRAIN
  } state_e;

  state_e                          state_q;
  logic                            in_ack_q;
  logic                            mem_req_q;
  logic                            res_req_q;
  pipe_pkg::ex_mem_t               in_q;
  logic [pipe_pkg::TRAP_LEN-1:0]   trap_q;
  logic [rv_isa_pkg::XLEN-1:0]     rdata_q;
  pipe_pkg::mem_wb_t               res_q;

  logic accept;
  logic op_lb, op_lbu, op_lh, op_lhu, op_lw, op_sb, op_sh, op_sw;
  logic is_load, is_store;
  logic ls_byte, ls_half, ls_word;
  logic ld_signed;
  logic [1:0] byte_off;
  logic misalign, mem_go;
  logic [3:0] base_mask;
  logic [rv_isa_pkg::XLEN-1:0] store_data;
  logic [rv_isa_pkg::XLEN-1:0] load_shifted;
  logic [rv_isa_pkg::XLEN-1:0] load_value;
  logic [rv_isa_pkg::XLEN-1:0] result;
  logic [pipe_pkg::TRAP_LEN-1:0] trap_out;

  assign accept = (state_q == ST_IDLE) && in_req_i && !in_ack_q;

  assign op_lb  = (in_q.memop == rv_isa_pkg::MEMOP_LB);
  assign op_lbu = (in_q.memop == rv_isa_pkg::MEMOP_LBU);
  assign op_lh  = (in_q.memop == rv_isa_pkg::MEMOP_LH);
  assign op_lhu = (in_q.memop == rv_isa_pkg::MEMOP_LHU);
  assign op_lw  = (in_q.memop == rv_isa_pkg::MEMOP_LW);
  assign op_sb  = (in_q.memop == rv_isa_pkg::MEMOP_SB);
  assign op_sh  = (in_q.memop == rv_isa_pkg::MEMOP_SH);
  assign op_sw  = (in_q.memop == rv_isa_pkg::MEMOP_SW);

  assign is_load   = op_lb | op_lbu | op_lh | op_lhu | op_lw;
  assign is_store  = op_sb | op_sh | op_sw;
  assign ls_byte   = op_lb | op_lbu | op_sb;
  assign ls_half   = op_lh | op_lhu | op_sh;
  assign ls_word   = op_lw | op_sw;
  assign ld_signed = op_lb | op_lh;  // LW needs no extension.

  assign byte_off = in_q.alu[1:0];
  assign misalign = (ls_half & byte_off[0]) | (ls_word & (byte_off != 2'b00));
  assign mem_go   = (is_load | is_store) & ~misalign;

  assign base_mask  = ({4{ls_byte}} & 4'b0001) |
                      ({4{ls_half}} & 4'b0011) |
                      ({4{ls_word}} & 4'b1111);
  assign store_data = ls_byte ? {{(rv_isa_pkg::XLEN-8){1'b0}}, in_q.rs2[7:0]} :
                      ls_half ? {{(rv_isa_pkg::XLEN-16){1'b0}}, in_q.rs2[15:0]} :
                      in_q.rs2;

  // RAM request fields come straight from the held item.
  assign mem_we_o    = is_store;
  assign mem_addr_o  = in_q.alu[AW+1:2];
  assign mem_wmask_o = is_store ? (base_mask << byte_off) : 4'b0000;
  assign mem_wdata_o = store_data << {byte_off, 3'b000};

  assign load_shifted = rdata_q >> {byte_off, 3'b000};

  always_comb begin
    if (ls_byte) begin
      load_value = {{(rv_isa_pkg::XLEN-8){ld_signed & load_shifted[7]}}, load_shifted[7:0]};
    end else if (ls_half) begin
      load_value = {{(rv_isa_pkg::XLEN-16){ld_signed & load_shifted[15]}},
                    load_shifted[15:0]};
    end else begin
      load_value = load_shifted;
    end
  end

  // A misaligned load never reads the RAM, so it keeps the ALU value.
  assign result = (is_load && !misalign) ? load_value : in_q.alu;

  always_comb begin
    trap_out = trap_q;
    trap_out[rv_isa_pkg::TRAP_LOAD_MISALIGN]  = trap_q[rv_isa_pkg::TRAP_LOAD_MISALIGN] |
                                                (is_load & misalign);
    trap_out[rv_isa_pkg::TRAP_STORE_MISALIGN] = trap_q[rv_isa_pkg::TRAP_STORE_MISALIGN] |
                                                (is_store & misalign);
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q   <= ST_IDLE;
      in_ack_q  <= 1'b0;
      mem_req_q <= 1'b0;
      res_req_q <= 1'b0;
    end else begin
      if (accept) in_ack_q <= 1'b1;
      else if (in_ack_q && !in_req_i) in_ack_q <= 1'b0;

      case (state_q)
        ST_IDLE: begin
          if (accept) state_q <= ST_DECODE;
        end
        ST_DECODE: begin
          if (mem_go) begin
            mem_req_q <= 1'b1;
            state_q   <= ST_MEM;
          end else begin
            state_q <= ST_FORMAT;  // Bypass the RAM.
          end
        end
        ST_MEM: begin
          if (mem_ack_i) begin
            mem_req_q <= 1'b0;
            state_q   <= ST_FORMAT;
          end
        end
        ST_FORMAT: begin
          res_req_q <= 1'b1;
          state_q   <= ST_RESP;
        end
        ST_RESP: begin
          if (res_ack_i) begin
            res_req_q <= 1'b0;
            state_q   <= ST_DRAIN;
          end
        end
        ST_DRAIN: begin
          if (!res_ack_i) state_q <= ST_IDLE;  // Ready for the next item.
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      in_q   <= in_data_i;
      trap_q <= in_trap_i;
    end
    if (state_q == ST_MEM && mem_ack_i) rdata_q <= mem_rdata_i;
    if (state_q == ST_FORMAT) begin
      res_q.pc   <= in_q.pc;
      res_q.inst <= in_q.inst;
      res_q.rd   <= in_q.rd;
      res_q.data <= result;
      res_q.trap <= trap_out;
    end
  end

  assign in_ack_o   = in_ack_q;
  assign mem_req_o  = mem_req_q;
  assign res_req_o  = res_req_q;
  assign res_data_o = res_q;

endmodule

//--- source/mem_subsys_top.sv
`timescale 1ns/1ps

module mem_subsys_top #(
  parameter int RAM_WORDS   = 256,
  parameter int RAM_LATENCY = 2
) (
  input  logic                               clk,
  input  logic                               rst_i,
  input  logic                               ex_req_i,
  output logic                               ex_ack_o,
  input  logic [rv_isa_pkg::XLEN-1:0]        ex_pc_i,
  input  logic [rv_isa_pkg::XLEN-1:0]        ex_inst_i,
  input  logic [rv_isa_pkg::RF_ADDR_W-1:0]   ex_rd_i,
  input  logic [rv_isa_pkg::XLEN-1:0]        ex_rs2_i,
  input  rv_isa_pkg::memop_e                 ex_memop_i,
  input  logic [rv_isa_pkg::XLEN-1:0]        ex_alu_i,
  input  logic [pipe_pkg::TRAP_LEN-1:0]      ex_trap_i,
  output logic                               wb_req_o,
  input  logic                               wb_ack_i,
  output logic [rv_isa_pkg::XLEN-1:0]        wb_pc_o,
  output logic [rv_isa_pkg::XLEN-1:0]        wb_inst_o,
  output logic [rv_isa_pkg::RF_ADDR_W-1:0]   wb_rd_o,
  output logic [rv_isa_pkg::XLEN-1:0]        wb_data_o,
  output logic [pipe_pkg::TRAP_LEN-1:0]      wb_trap_o
);

  // The ex/mem register also carries the trap bus next to the payload.
  localparam int EX_W = $bits(pipe_pkg::ex_mem_t) + pipe_pkg::TRAP_LEN;
  typedef logic [EX_W-1:0] ex_word_t;

  pipe_pkg::ex_mem_t              ex_pkt;
  ex_word_t                       stg_word;
  pipe_pkg::ex_mem_t              stg_data;
  logic [pipe_pkg::TRAP_LEN-1:0]  stg_trap;
  logic                           stg_req, stg_ack;

  logic                               mem_req, mem_ack, mem_we;
  logic [$clog2(RAM_WORDS)-1:0]       mem_addr;
  logic [3:0]                         mem_wmask;
  logic [rv_isa_pkg::XLEN-1:0]        mem_wdata, mem_rdata;

  logic                res_req, res_ack;
  pipe_pkg::mem_wb_t   res_data;
  pipe_pkg::mem_wb_t   wb_data;

  assign ex_pkt.pc    = ex_pc_i;
  assign ex_pkt.inst  = ex_inst_i;
  assign ex_pkt.rd    = ex_rd_i;
  assign ex_pkt.rs2   = ex_rs2_i;
  assign ex_pkt.memop = ex_memop_i;
  assign ex_pkt.alu   = ex_alu_i;

  assign {stg_trap, stg_data} = stg_word;

  pipe_stage_reg #(.payload_t(ex_word_t)) u_ex_mem (
    .clk       (clk),
    .rst_i     (rst_i),
    .in_req_i  (ex_req_i),
    .in_ack_o  (ex_ack_o),
    .in_data_i ({ex_trap_i, ex_pkt}),
    .out_req_o (stg_req),
    .out_ack_i (stg_ack),
    .out_data_o(stg_word)
  );

  mem_access_stage #(.RAM_WORDS(RAM_WORDS)) u_mem_stage (
    .clk        (clk),
    .rst_i      (rst_i),
    .in_req_i   (stg_req),
    .in_ack_o   (stg_ack),
    .in_data_i  (stg_data),
    .in_trap_i  (stg_trap),
    .mem_req_o  (mem_req),
    .mem_ack_i  (mem_ack),
    .mem_we_o   (mem_we),
    .mem_addr_o (mem_addr),
    .mem_wmask_o(mem_wmask),
    .mem_wdata_o(mem_wdata),
    .mem_rdata_i(mem_rdata),
    .res_req_o  (res_req),
    .res_ack_i  (res_ack),
    .res_data_o (res_data)
  );

  data_ram #(.RAM_WORDS(RAM_WORDS), .RAM_LATENCY(RAM_LATENCY)) u_ram (
    .clk        (clk),
    .rst_i      (rst_i),
    .mem_req_i  (mem_req),
    .mem_ack_o  (mem_ack),
    .mem_we_i   (mem_we),
    .mem_addr_i (mem_addr),
    .mem_wmask_i(mem_wmask),
    .mem_wdata_i(mem_wdata),
    .mem_rdata_o(mem_rdata)
  );

  pipe_stage_reg #(.payload_t(pipe_pkg::mem_wb_t)) u_mem_wb (
    .clk       (clk),
    .rst_i     (rst_i),
    .in_req_i  (res_req),
    .in_ack_o  (res_ack),
    .in_data_i (res_data),
    .out_req_o (wb_req_o),
    .out_ack_i (wb_ack_i),
    .out_data_o(wb_data)
  );

  assign wb_pc_o   = wb_data.pc;
  assign wb_inst_o = wb_data.inst;
  assign wb_rd_o   = wb_data.rd;
  assign wb_data_o = wb_data.data;
  assign wb_trap_o = wb_data.trap;

endmodule

//--- source/pipe_pkg.sv
package pipe_pkg;

  // Width of the trap bus that runs down the pipeline.
  localparam int TRAP_LEN = 16;

  // Execute to memory payload. The trap bus travels next to it.
  typedef struct packed {
    logic [rv_isa_pkg::XLEN-1:0]      pc;
    logic [rv_isa_pkg::XLEN-1:0]      inst;
    logic [rv_isa_pkg::RF_ADDR_W-1:0] rd;
    logic [rv_isa_pkg::XLEN-1:0]      rs2;    // Store data.
    rv_isa_pkg::memop_e               memop;
    logic [rv_isa_pkg::XLEN-1:0]      alu;    // ALU result, also the address.
  } ex_mem_t;

  // Memory to writeback payload.
  typedef struct packed {
    logic [rv_isa_pkg::XLEN-1:0]      pc;
    logic [rv_isa_pkg::XLEN-1:0]      inst;
    logic [rv_isa_pkg::RF_ADDR_W-1:0] rd;
    logic [rv_isa_pkg::XLEN-1:0]      data;   // Load value or ALU result.
    logic [TRAP_LEN-1:0]              trap;
  } mem_wb_t;

endpackage

//--- source/pipe_stage_reg.sv
`timescale 1ns/1ps

module pipe_stage_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_i,
  input  logic     in_req_i,
  output logic     in_ack_o,
  input  payload_t in_data_i,
  output logic     out_req_o,
  input  logic     out_ack_i,
  output payload_t out_data_o
);

  logic     full_q;       // An item is held.
  logic     in_ack_q;
  logic     out_req_q;
  logic     out_drain_q;  // Out side waits for ack to fall.
  payload_t data_q;

  logic capture;

  // Take a new item only when empty and the previous in handshake is closed.
  assign capture = in_req_i && !full_q && !in_ack_q;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      full_q      <= 1'b0;
      in_ack_q    <= 1'b0;
      out_req_q   <= 1'b0;
      out_drain_q <= 1'b0;
    end else begin
      if (capture) begin
        full_q   <= 1'b1;
        in_ack_q <= 1'b1;
      end else if (in_ack_q && !in_req_i) begin
        in_ack_q <= 1'b0;  // Sender released req.
      end

      if (full_q && !out_req_q && !out_drain_q) begin
        out_req_q <= 1'b1;  // One cycle after capture.
      end else if (out_req_q && out_ack_i) begin
        out_req_q   <= 1'b0;
        out_drain_q <= 1'b1;
      end else if (out_drain_q && !out_ack_i) begin
        out_drain_q <= 1'b0;
        full_q      <= 1'b0;  // Empty again.
      end
    end
  end

  always_ff @(posedge clk) begin
    if (capture) data_q <= in_data_i;
  end

  assign in_ack_o   = in_ack_q;
  assign out_req_o  = out_req_q;
  assign out_data_o = data_q;

endmodule

//--- source/rv_isa_pkg.sv
package rv_isa_pkg;

  // Data and address width of the core.
  localparam int XLEN = 32;

  // Width of a register file index.
  localparam int RF_ADDR_W = 5;

  // Memory opcode as produced by the decode stage.
  typedef enum logic [3:0] {
    MEMOP_NONE = 4'd0,  // Not a memory instruction.
    MEMOP_LB   = 4'd1,
    MEMOP_LBU  = 4'd2,
    MEMOP_LH   = 4'd3,
    MEMOP_LHU  = 4'd4,
    MEMOP_LW   = 4'd5,
    MEMOP_SB   = 4'd6,
    MEMOP_SH   = 4'd7,
    MEMOP_SW   = 4'd8
  } memop_e;

  // Trap bus bit positions, matching the mcause exception codes.
  localparam int TRAP_LOAD_MISALIGN  = 4;  // Load address misaligned.
  localparam int TRAP_STORE_MISALIGN = 6;  // Store/AMO address misaligned.

endpackage

//--- testbench/mem_subsys_checker.sv
`timescale 1ns/1ps

module mem_subsys_checker (
  input logic                             clk,
  input logic                             rst_i,
  input logic                             mem_req_i,
  input logic                             mem_ack_i,
  input logic                             ex_ack_i,
  input logic                             wb_req_i,
  input logic                             wb_ack_i,
  input logic [rv_isa_pkg::XLEN-1:0]      wb_pc_i,
  input logic [rv_isa_pkg::XLEN-1:0]      wb_inst_i,
  input logic [rv_isa_pkg::RF_ADDR_W-1:0] wb_rd_i,
  input logic [rv_isa_pkg::XLEN-1:0]      wb_data_i,
  input logic [pipe_pkg::TRAP_LEN-1:0]    wb_trap_i
);

  localparam int PAY_W = 3 * rv_isa_pkg::XLEN + rv_isa_pkg::RF_ADDR_W + pipe_pkg::TRAP_LEN;

  logic [PAY_W-1:0] wb_payload;

  assign wb_payload = {wb_pc_i, wb_inst_i, wb_rd_i, wb_data_i, wb_trap_i};

  ram_req_hold: assert property (@(posedge clk) disable iff (rst_i)
    mem_req_i && !mem_ack_i |=> mem_req_i)
    else $error("RAM request dropped before its acknowledge");

  wb_req_hold: assert property (@(posedge clk) disable iff (rst_i)
    wb_req_i && !wb_ack_i |=> wb_req_i)
    else $error("Writeback request dropped before its acknowledge");

  // Payload may only change once the request is gone.
  wb_payload_stable: assert property (@(posedge clk) disable iff (rst_i)
    wb_req_i |=> !wb_req_i || $stable(wb_payload))
    else $error("Writeback payload changed while the request was high");

  reset_quiet: assert property (@(posedge clk)
    rst_i |=> !wb_req_i && !ex_ack_i)
    else $error("Handshake outputs high in the cycle after reset");

endmodule

bind mem_subsys_top mem_subsys_checker u_checker (
  .clk      (clk),
  .rst_i    (rst_i),
  .mem_req_i(mem_req),
  .mem_ack_i(mem_ack),
  .ex_ack_i (ex_ack_o),
  .wb_req_i (wb_req_o),
  .wb_ack_i (wb_ack_i),
  .wb_pc_i  (wb_pc_o),
  .wb_inst_i(wb_inst_o),
  .wb_rd_i  (wb_rd_o),
  .wb_data_i(wb_data_o),
  .wb_trap_i(wb_trap_o)
);

//--- testbench/mem_subsys_tb.sv
`timescale 1ns/1ps

module mem_subsys_tb;

  localparam int RAM_WORDS      = 256;
  localparam int RAM_LATENCY    = 2;
  localparam int NUM            = 24;
  localparam int TIMEOUT_CYCLES = NUM * (RAM_LATENCY + 12) + 50;
  localparam int BA_W           = $clog2(4 * RAM_WORDS);  // Byte address width.

  logic                               clk;
  logic                               rst;
  logic                               ex_req, ex_ack, wb_req, wb_ack;
  logic [rv_isa_pkg::XLEN-1:0]        ex_pc, ex_inst, ex_rs2, ex_alu;
  logic [rv_isa_pkg::RF_ADDR_W-1:0]   ex_rd, wb_rd;
  rv_isa_pkg::memop_e                 ex_memop;
  logic [pipe_pkg::TRAP_LEN-1:0]      ex_trap, wb_trap;
  logic [rv_isa_pkg::XLEN-1:0]        wb_pc, wb_inst, wb_data;

  // Stimulus table and the expected results derived from it.
  string                         t_name   [NUM];
  rv_isa_pkg::memop_e            t_op     [NUM];
  logic [rv_isa_pkg::XLEN-1:0]   t_addr   [NUM];
  logic [rv_isa_pkg::XLEN-1:0]   t_rs2    [NUM];
  logic [pipe_pkg::TRAP_LEN-1:0] t_trap   [NUM];
  logic [rv_isa_pkg::XLEN-1:0]   exp_data [NUM];
  logic [pipe_pkg::TRAP_LEN-1:0] exp_trap [NUM];
  logic [7:0]                    ref_mem  [4*RAM_WORDS];  // Byte model of the RAM.
  int                            exp_idx_q [$];           // Entries waiting for writeback.

  int num_entries = 0;
  int recv_count  = 0;
  int checks      = 0;
  int errors      = 0;
  int cycle_count = 0;

  tb_clock_gen #(.PERIOD_NS(8), .RESET_CYCLES(4)) u_clk_gen (
    .clk_o(clk),
    .rst_o(rst)
  );

  mem_subsys_top #(.RAM_WORDS(RAM_WORDS), .RAM_LATENCY(RAM_LATENCY)) u_dut (
    .clk       (clk),
    .rst_i     (rst),
    .ex_req_i  (ex_req),
    .ex_ack_o  (ex_ack),
    .ex_pc_i   (ex_pc),
    .ex_inst_i (ex_inst),
    .ex_rd_i   (ex_rd),
    .ex_rs2_i  (ex_rs2),
    .ex_memop_i(ex_memop),
    .ex_alu_i  (ex_alu),
    .ex_trap_i (ex_trap),
    .wb_req_o  (wb_req),
    .wb_ack_i  (wb_ack),
    .wb_pc_o   (wb_pc),
    .wb_inst_o (wb_inst),
    .wb_rd_o   (wb_rd),
    .wb_data_o (wb_data),
    .wb_trap_o (wb_trap)
  );

  function automatic logic [31:0] pc_of(input int i);
    return 32'h0000_1000 + 32'(4 * i);
  endfunction

  function automatic logic [31:0] inst_of(input int i);
    return 32'h0000_2003 ^ (32'(i) << 15);  // Varies the rs1 field.
  endfunction

  function automatic logic [4:0] rd_of(input int i);
    return 5'(i + 1);
  endfunction

  function automatic int op_size(input rv_isa_pkg::memop_e op);
    case (op)
      rv_isa_pkg::MEMOP_LB, rv_isa_pkg::MEMOP_LBU, rv_isa_pkg::MEMOP_SB: return 1;
      rv_isa_pkg::MEMOP_LH, rv_isa_pkg::MEMOP_LHU, rv_isa_pkg::MEMOP_SH: return 2;
      rv_isa_pkg::MEMOP_LW, rv_isa_pkg::MEMOP_SW: return 4;
      default: return 0;
    endcase
  endfunction

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAIL %s: expected %h, actual %h", what, expected, actual);
    end
  endtask

  task automatic add_entry(input string name, input rv_isa_pkg::memop_e op,
                           input logic [31:0] addr, input logic [31:0] rs2,
                           input logic [15:0] trap);
    t_name[num_entries] = name;
    t_op[num_entries]   = op;
    t_addr[num_entries] = addr;
    t_rs2[num_entries]  = rs2;
    t_trap[num_entries] = trap;
    num_entries++;
  endtask

  task automatic build_table();
    add_entry("sw_word",   rv_isa_pkg::MEMOP_SW,   32'h0000_0100, 32'hDEAD_BEEF, 16'h0000);
    add_entry("lw_word",   rv_isa_pkg::MEMOP_LW,   32'h0000_0100, 32'h0000_0000, 16'h0000);
    add_entry("sb_off0",   rv_isa_pkg::MEMOP_SB,   32'h0000_0200, 32'h5555_AA81, 16'h0000);
    add_entry("sb_off1",   rv_isa_pkg::MEMOP_SB,   32'h0000_0201, 32'h0000_007F, 16'h0000);
    add_entry("sb_off2",   rv_isa_pkg::MEMOP_SB,   32'h0000_0202, 32'hFFFF_FFC3, 16'h0000);
    add_entry("sb_off3",   rv_isa_pkg::MEMOP_SB,   32'h0000_0203, 32'hAABB_CC12, 16'h0000);
    add_entry("lb_off0",   rv_isa_pkg::MEMOP_LB,   32'h0000_0200, 32'h0000_0000, 16'h0000);
    add_entry("lbu_off0",  rv_isa_pkg::MEMOP_LBU,  32'h0000_0200, 32'h0000_0000, 16'h0000);
    add_entry("lb_off1",   rv_isa_pkg::MEMOP_LB,   32'h0000_0201, 32'h0000_0000, 16'h0000);
    add_entry("lbu_off2",  rv_isa_pkg::MEMOP_LBU,  32'h0000_0202, 32'h0000_0000, 16'h0000);
    add_entry("lb_off2",   rv_isa_pkg::MEMOP_LB,   32'h0000_0202, 32'h0000_0000, 16'h0000);
    add_entry("lb_off3",   rv_isa_pkg::MEMOP_LB,   32'h0000_0203, 32'h0000_0000, 16'h0000);
    add_entry("sh_off0",   rv_isa_pkg::MEMOP_SH,   32'h0000_0300, 32'h1234_F00D, 16'h0000);
    add_entry("sh_off2",   rv_isa_pkg::MEMOP_SH,   32'h0000_0302, 32'h0000_8001, 16'h0000);
    add_entry("lh_off0",   rv_isa_pkg::MEMOP_LH,   32'h0000_0300, 32'h0000_0000, 16'h0000);
    add_entry("lhu_off2",  rv_isa_pkg::MEMOP_LHU,  32'h0000_0302, 32'h0000_0000, 16'h0000);
    add_entry("lh_off2",   rv_isa_pkg::MEMOP_LH,   32'h0000_0302, 32'h0000_0000, 16'h0000);
    add_entry("lw_halves", rv_isa_pkg::MEMOP_LW,   32'h0000_0300, 32'h0000_0000, 16'h0000);
    add_entry("lhu_bytes", rv_isa_pkg::MEMOP_LHU,  32'h0000_0200, 32'h0000_0000, 16'h0000);
    add_entry("alu_plain", rv_isa_pkg::MEMOP_NONE, 32'h1234_5678, 32'hFFFF_FFFF, 16'h0000);
    add_entry("alu_trap",  rv_isa_pkg::MEMOP_NONE, 32'hCAFE_0000, 32'h0000_0000, 16'h0004);
    add_entry("lh_misal",  rv_isa_pkg::MEMOP_LH,   32'h0000_0301, 32'h0000_0000, 16'h0100);
    add_entry("sw_misal",  rv_isa_pkg::MEMOP_SW,   32'h0000_0102, 32'hFFFF_FFFF, 16'h0001);
    add_entry("lw_after",  rv_isa_pkg::MEMOP_LW,   32'h0000_0100, 32'h0000_0000, 16'h0000);
  endtask

  // Applies one entry to the byte model and records its expected result.
  task automatic model_entry(input int i);
    int              size;
    int              k;
    logic            is_ld;
    logic            is_st;
    logic            misal;
    logic [BA_W-1:0] ba;
    logic [31:0]     v;
    size  = op_size(t_op[i]);
    is_ld = t_op[i] inside {rv_isa_pkg::MEMOP_LB, rv_isa_pkg::MEMOP_LBU, rv_isa_pkg::MEMOP_LH,
                            rv_isa_pkg::MEMOP_LHU, rv_isa_pkg::MEMOP_LW};
    is_st = t_op[i] inside {rv_isa_pkg::MEMOP_SB, rv_isa_pkg::MEMOP_SH, rv_isa_pkg::MEMOP_SW};
    misal = (size == 2 && t_addr[i][0]) || (size == 4 && t_addr[i][1:0] != 2'b00);
    ba    = t_addr[i][BA_W-1:0];
    v     = 32'h0;
    exp_data[i] = t_addr[i];  // ALU value unless a load reads memory.
    exp_trap[i] = t_trap[i];
    if (misal && is_ld) begin
      exp_trap[i][rv_isa_pkg::TRAP_LOAD_MISALIGN] = 1'b1;
    end else if (misal) begin
      exp_trap[i][rv_isa_pkg::TRAP_STORE_MISALIGN] = 1'b1;
    end else if (is_st) begin
      for (k = 0; k < size; k++) begin
        ref_mem[ba + BA_W'(k)] = 8'(t_rs2[i] >> (8 * k));  // Little endian.
      end
    end else if (is_ld) begin
      for (k = 0; k < size; k++) begin
        v = v | (32'(ref_mem[ba + BA_W'(k)]) << (8 * k));
      end
      if (t_op[i] == rv_isa_pkg::MEMOP_LB) begin
        v = {{24{v[7]}}, v[7:0]};
      end else if (t_op[i] == rv_isa_pkg::MEMOP_LH) begin
        v = {{16{v[15]}}, v[15:0]};
      end
      exp_data[i] = v;
    end
  endtask

  task automatic send_entry(input int i);
    @(negedge clk);
    ex_pc    = pc_of(i);
    ex_inst  = inst_of(i);
    ex_rd    = rd_of(i);
    ex_rs2   = t_rs2[i];
    ex_memop = t_op[i];
    ex_alu   = t_addr[i];
    ex_trap  = t_trap[i];
    ex_req   = 1'b1;
    model_entry(i);
    exp_idx_q.push_back(i);
    while (!ex_ack) @(negedge clk);
    ex_req = 1'b0;
    while (ex_ack) @(negedge clk);  // Four-phase close.
  endtask

  // Writeback side with random back-pressure.
  initial begin : wb_responder
    int delay;
    int idx;
    wb_ack = 1'b0;
    void'($urandom(1678));
    forever begin
      @(negedge clk);
      if (!rst && wb_req) begin
        delay = $urandom_range(5, 0);
        repeat (delay) @(negedge clk);
        if (exp_idx_q.size() == 0) begin
          errors++;
          $display("Result with pc %h arrived while no entry was outstanding", wb_pc);
        end else begin
          idx = exp_idx_q.pop_front();
          check_value({t_name[idx], " pc"}, pc_of(idx), wb_pc);
          check_value({t_name[idx], " inst"}, inst_of(idx), wb_inst);
          check_value({t_name[idx], " rd"}, 32'(rd_of(idx)), 32'(wb_rd));
          check_value({t_name[idx], " data"}, exp_data[idx], wb_data);
          check_value({t_name[idx], " trap"}, 32'(exp_trap[idx]), 32'(wb_trap));
        end
        wb_ack = 1'b1;
        while (wb_req) @(negedge clk);
        wb_ack = 1'b0;
        recv_count++;
      end
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, %0d of %0d results received",
               cycle_count, recv_count, num_entries);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  initial begin : main_seq
    int i;
    ex_req   = 1'b0;
    ex_pc    = '0;
    ex_inst  = '0;
    ex_rd    = '0;
    ex_rs2   = '0;
    ex_memop = rv_isa_pkg::MEMOP_NONE;
    ex_alu   = '0;
    ex_trap  = '0;
    build_table();
    @(negedge rst);
    repeat (3) begin
      @(negedge clk);
      check_value("wb_req idle after reset", 32'h0, 32'(wb_req));
    end
    for (i = 0; i < num_entries; i++) begin
      send_entry(i);
    end
    while (recv_count < num_entries) @(negedge clk);
    repeat (5) @(negedge clk);
    check_value("results outstanding", 32'h0, 32'(exp_idx_q.size()));
    check_value("results received", 32'(num_entries), 32'(recv_count));
    check_value("wb_req after drain", 32'h0, 32'(wb_req));
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 4
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0;  // Released on a falling edge.
  end

endmodule
